// File: all.f
+incdir+rtl
rtl/afifo_pkg.sv
rtl/axil_write_slave.sv
rtl/afifo_core.sv
rtl/periph_read_port.sv
rtl/axil_status_read.sv
rtl/afifo_axil_top.sv
bench/tb_afifo_axil.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --timing --assert
TOP        := tb_afifo_axil
FILELIST   := all.f
BUILD_DIR  := obj_dir
SIM_BIN    := $(BUILD_DIR)/V$(TOP)
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_afifo_axil.sv
`timescale 1ns/10ps
`default_nettype none

module tb_afifo_axil;

    import afifo_pkg::*;

    localparam int AXI_HALF_NS    = 4;
    localparam int PERIPH_HALF_NS = 6;
    localparam int RESET_CYCLES   = 16;
    // cap on any single wait for a handshake
    localparam int HS_CAP         = 64;
    // 6 tests of under 400 clk_axi cycles each rounded up to whole microseconds
    localparam int TESTS          = 6;
    localparam int TEST_CYCLES    = 400;
    localparam int WATCHDOG_NS    = (TESTS * TEST_CYCLES * 2 * AXI_HALF_NS / 1000 + 1) * 1000;

    logic       clk_axi;
    logic       clk_periph;
    logic       axi_resetn;
    axil_addr_t axi_awaddr;
    logic       axi_awvalid;
    logic       axi_awready;
    data_t      axi_wdata;
    logic       axi_wvalid;
    logic       axi_wready;
    resp_t      axi_bresp;
    logic       axi_bvalid;
    logic       axi_bready;
    axil_addr_t axi_araddr;
    logic       axi_arvalid;
    logic       axi_arready;
    data_t      axi_rdata;
    resp_t      axi_rresp;
    logic       axi_rvalid;
    logic       axi_rready;
    logic       periph_rd_en;
    data_t      periph_rdata;
    logic       periph_rvalid;
    logic       periph_empty;
    logic       periph_full;

    // words written with OKAY in push order
    data_t      expected_q[$];
    logic [31:0] lfsr_q;
    string      test_name;
    int         err_count;
    int         test_errs_start;
    int         tests_run;
    int         tests_failed;

    afifo_axil_top u_afifo_axil_top (
        .clk_axi         (clk_axi),
        .clk_periph      (clk_periph),
        .axi_resetn_i    (axi_resetn),
        .axi_awaddr_i    (axi_awaddr),
        .axi_awvalid_i   (axi_awvalid),
        .axi_awready_o   (axi_awready),
        .axi_wdata_i     (axi_wdata),
        .axi_wvalid_i    (axi_wvalid),
        .axi_wready_o    (axi_wready),
        .axi_bresp_o     (axi_bresp),
        .axi_bvalid_o    (axi_bvalid),
        .axi_bready_i    (axi_bready),
        .axi_araddr_i    (axi_araddr),
        .axi_arvalid_i   (axi_arvalid),
        .axi_arready_o   (axi_arready),
        .axi_rdata_o     (axi_rdata),
        .axi_rresp_o     (axi_rresp),
        .axi_rvalid_o    (axi_rvalid),
        .axi_rready_i    (axi_rready),
        .periph_rd_en_i  (periph_rd_en),
        .periph_rdata_o  (periph_rdata),
        .periph_rvalid_o (periph_rvalid),
        .periph_empty_o  (periph_empty),
        .periph_full_o   (periph_full)
    );

    // --------------------------------------------------
    // clocks and watchdog
    // --------------------------------------------------
    initial begin
        clk_axi = 1'b0;
        forever #(AXI_HALF_NS) clk_axi = ~clk_axi;
    end

    initial begin
        clk_periph = 1'b0;
        forever #(PERIPH_HALF_NS) clk_periph = ~clk_periph;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests never finished", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    // --------------------------------------------------
    // reporting and stimulus helpers
    // --------------------------------------------------
    task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
        err_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("[ERROR] %s: %s", test_name, msg);
        err_count++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs_start = err_count;
        tests_run++;
    endtask

    task automatic finish_test();
        if (err_count == test_errs_start) begin
            $display("test %0d %s: passed", tests_run, test_name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests_run, test_name,
                     err_count - test_errs_start);
            tests_failed++;
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic data_t next_rand_word();
        data_t word;
        logic  fb;
        word = '0;
        for (int i = 0; i < $bits(data_t); i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            word = {word[$bits(data_t)-2:0], fb};
        end
        return word;
    endfunction

    // AW and W start after their own lags and bready stays low for b_hold cycles
    task automatic axi_write(input data_t data, input int aw_lag, input int w_lag,
                             input int b_hold, output resp_t resp);
        int    cyc;
        logic  aw_done;
        logic  w_done;
        logic  aw_hs;
        logic  w_hs;
        resp_t first_resp;
        cyc = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        resp = RESP_SLVERR;
        @(negedge clk_axi);
        axi_wdata = data;
        while (!(aw_done && w_done) && cyc < HS_CAP) begin
            axi_awvalid = !aw_done && (cyc >= aw_lag);
            axi_wvalid  = !w_done && (cyc >= w_lag);
            // ready depends only on the state and is already settled here
            aw_hs = axi_awvalid && axi_awready;
            w_hs  = axi_wvalid && axi_wready;
            @(negedge clk_axi);
            if (aw_hs) begin
                aw_done = 1'b1;
            end
            if (w_hs) begin
                w_done = 1'b1;
            end
            cyc++;
        end
        axi_awvalid = 1'b0;
        axi_wvalid  = 1'b0;
        if (!(aw_done && w_done)) begin
            report_problem("write address or data was never accepted");
            return;
        end
        cyc = 0;
        while (!axi_bvalid && cyc < HS_CAP) begin
            @(negedge clk_axi);
            cyc++;
        end
        if (!axi_bvalid) begin
            report_problem("no write response arrived");
            return;
        end
        first_resp = axi_bresp;
        repeat (b_hold) begin
            @(negedge clk_axi);
            if (!axi_bvalid) begin
                report_problem("bvalid dropped while bready was low");
            end
            if (axi_bresp !== first_resp) begin
                value_error("bresp while held", 32'(first_resp), 32'(axi_bresp));
            end
            if (axi_awready) begin
                report_problem("awready rose while a response was pending");
            end
            if (axi_wready) begin
                report_problem("wready rose while a response was pending");
            end
        end
        axi_bready = 1'b1;
        @(negedge clk_axi);
        axi_bready = 1'b0;
        resp = first_resp;
    endtask

    task automatic axi_read(input axil_addr_t addr, input int r_hold,
                            output data_t data, output resp_t resp);
        int cyc;
        cyc = 0;
        data = '0;
        resp = RESP_SLVERR;
        @(negedge clk_axi);
        axi_araddr  = addr;
        axi_arvalid = 1'b1;
        while (!axi_arready && cyc < HS_CAP) begin
            @(negedge clk_axi);
            cyc++;
        end
        @(negedge clk_axi);
        axi_arvalid = 1'b0;
        cyc = 0;
        while (!axi_rvalid && cyc < HS_CAP) begin
            @(negedge clk_axi);
            cyc++;
        end
        if (!axi_rvalid) begin
            report_problem("no read data arrived");
            return;
        end
        data = axi_rdata;
        resp = axi_rresp;
        repeat (r_hold) begin
            @(negedge clk_axi);
            if (!axi_rvalid) begin
                report_problem("rvalid dropped while rready was low");
            end
            if (axi_rdata !== data) begin
                value_error("rdata while held", data, axi_rdata);
            end
            if (axi_rresp !== resp) begin
                value_error("rresp while held", 32'(resp), 32'(axi_rresp));
            end
            if (axi_arready) begin
                report_problem("arready rose while read data was pending");
            end
        end
        axi_rready = 1'b1;
        @(negedge clk_axi);
        axi_rready = 1'b0;
    endtask

    task automatic periph_pop(output data_t data, output logic got);
        int cyc;
        cyc = 0;
        data = '0;
        got = 1'b0;
        @(negedge clk_periph);
        // empty falls only after the write pointer crosses over
        while (periph_empty && cyc < HS_CAP) begin
            @(negedge clk_periph);
            cyc++;
        end
        if (periph_empty) begin
            report_problem("FIFO stayed empty on the peripheral side");
            return;
        end
        periph_rd_en = 1'b1;
        @(negedge clk_periph);
        periph_rd_en = 1'b0;
        if (!periph_rvalid) begin
            report_problem("no valid pulse after a pop");
            return;
        end
        data = periph_rdata;
        got = 1'b1;
    endtask

    task automatic write_expect(input data_t data, input resp_t exp_resp);
        resp_t resp;
        axi_write(data, 0, 0, 0, resp);
        if (resp !== exp_resp) begin
            value_error("bresp", 32'(exp_resp), 32'(resp));
        end
        if (exp_resp == RESP_OKAY) begin
            expected_q.push_back(data);
        end
    endtask

    task automatic pop_compare();
        data_t data;
        data_t exp;
        logic  got;
        periph_pop(data, got);
        if (got) begin
            if (expected_q.size() == 0) begin
                report_problem("a word popped out that was never written");
            end else begin
                exp = expected_q.pop_front();
                if (data !== exp) begin
                    value_error("popped word", exp, data);
                end
            end
        end
    endtask

    task automatic status_expect(input axil_addr_t addr, input data_t exp_data,
                                 input resp_t exp_resp);
        data_t data;
        resp_t resp;
        axi_read(addr, 0, data, resp);
        if (data !== exp_data) begin
            value_error("read data", exp_data, data);
        end
        if (resp !== exp_resp) begin
            value_error("rresp", 32'(exp_resp), 32'(resp));
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset_state();
        start_test("reset_state");
        if (axi_bvalid || axi_rvalid || periph_rvalid) begin
            report_problem("a valid output is high after reset");
        end
        if (!periph_empty) begin
            report_problem("peripheral empty flag is low after reset");
        end
        // empty only
        status_expect(STATUS_ADDR, 32'h0000_0001, RESP_OKAY);
        finish_test();
    endtask

    task automatic test_ordered_transfer();
        start_test("ordered_transfer");
        @(negedge clk_periph);
        periph_rd_en = 1'b1;
        repeat (3) begin
            @(negedge clk_periph);
            if (periph_rvalid) begin
                report_problem("valid pulsed on a read of an empty FIFO");
            end
        end
        periph_rd_en = 1'b0;
        repeat (5) begin
            write_expect(next_rand_word(), RESP_OKAY);
        end
        repeat (5) begin
            pop_compare();
        end
        finish_test();
    endtask

    task automatic test_split_channels();
        data_t data;
        resp_t resp;
        start_test("split_channels");
        // address three cycles ahead of data
        data = next_rand_word();
        axi_write(data, 0, 3, 0, resp);
        if (resp !== RESP_OKAY) begin
            value_error("bresp aw first", 32'(RESP_OKAY), 32'(resp));
        end
        expected_q.push_back(data);
        // then the reverse
        data = next_rand_word();
        axi_write(data, 3, 0, 0, resp);
        if (resp !== RESP_OKAY) begin
            value_error("bresp w first", 32'(RESP_OKAY), 32'(resp));
        end
        expected_q.push_back(data);
        repeat (2) begin
            pop_compare();
        end
        finish_test();
    endtask

    task automatic test_full_slverr();
        start_test("full_slverr");
        // let the last pops reach the AXI side
        repeat (10) @(negedge clk_axi);
        repeat (8) begin
            write_expect(next_rand_word(), RESP_OKAY);
        end
        repeat (10) @(negedge clk_axi);
        if (periph_full !== 1'b1) begin
            value_error("periph_full", 32'd1, 32'(periph_full));
        end
        // occupancy 8 in bits 15:8 and full in bit 1
        status_expect(STATUS_ADDR, (32'd8 << 8) | 32'h2, RESP_OKAY);
        write_expect(next_rand_word(), RESP_SLVERR);
        repeat (8) begin
            pop_compare();
        end
        if (expected_q.size() != 0) begin
            report_problem("words were left in the scoreboard after draining");
        end
        finish_test();
    endtask

    task automatic test_drain_bad_addr();
        start_test("drain_bad_addr");
        repeat (10) @(negedge clk_axi);
        if (periph_full !== 1'b0) begin
            value_error("periph_full", 32'd0, 32'(periph_full));
        end
        status_expect(STATUS_ADDR, 32'h0000_0001, RESP_OKAY);
        status_expect(axil_addr_t'(4'h4), 32'h0, RESP_SLVERR);
        finish_test();
    endtask

    task automatic test_back_pressure();
        data_t data;
        data_t rd;
        resp_t resp;
        start_test("back_pressure");
        data = next_rand_word();
        axi_write(data, 0, 0, 6, resp);
        if (resp !== RESP_OKAY) begin
            value_error("bresp", 32'(RESP_OKAY), 32'(resp));
        end
        expected_q.push_back(data);
        pop_compare();
        repeat (10) @(negedge clk_axi);
        axi_read(STATUS_ADDR, 6, rd, resp);
        if (rd !== 32'h0000_0001) begin
            value_error("status held", 32'h0000_0001, rd);
        end
        if (resp !== RESP_OKAY) begin
            value_error("rresp held", 32'(RESP_OKAY), 32'(resp));
        end
        finish_test();
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        axi_resetn   = 1'b0;
        axi_awaddr   = '0;
        axi_awvalid  = 1'b0;
        axi_wdata    = '0;
        axi_wvalid   = 1'b0;
        axi_bready   = 1'b0;
        axi_araddr   = '0;
        axi_arvalid  = 1'b0;
        axi_rready   = 1'b0;
        periph_rd_en = 1'b0;
        lfsr_q       = 32'd3147;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "setup";
        repeat (RESET_CYCLES) @(posedge clk_axi);
        @(negedge clk_axi);
        axi_resetn = 1'b1;
        @(negedge clk_axi);

        test_reset_state();
        test_ordered_transfer();
        test_split_channels();
        test_full_slverr();
        test_drain_bad_addr();
        test_back_pressure();

        $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/afifo_axil_top.sv
`timescale 1ns/10ps
`default_nettype none

module afifo_axil_top (
    input  wire                        clk_axi,
    input  wire                        clk_periph,
    input  wire                        axi_resetn_i,
    // write address, the address itself is not decoded
    input  wire afifo_pkg::axil_addr_t axi_awaddr_i,
    input  wire                        axi_awvalid_i,
    output logic                       axi_awready_o,
    // write data
    input  wire afifo_pkg::data_t      axi_wdata_i,
    input  wire                        axi_wvalid_i,
    output logic                       axi_wready_o,
    // write response
    output afifo_pkg::resp_t           axi_bresp_o,
    output logic                       axi_bvalid_o,
    input  wire                        axi_bready_i,
    // read address
    input  wire afifo_pkg::axil_addr_t axi_araddr_i,
    input  wire                        axi_arvalid_i,
    output logic                       axi_arready_o,
    // read data
    output afifo_pkg::data_t           axi_rdata_o,
    output afifo_pkg::resp_t           axi_rresp_o,
    output logic                       axi_rvalid_o,
    input  wire                        axi_rready_i,
    // peripheral side, clk_periph
    input  wire                        periph_rd_en_i,
    output afifo_pkg::data_t           periph_rdata_o,
    output logic                       periph_rvalid_o,
    output logic                       periph_empty_o,
    output logic                       periph_full_o
);

    import afifo_pkg::*;

    logic  push;
    data_t push_data;
    logic  pop;
    logic  full;
    logic  empty_axi;
    logic  empty_periph;
    ptr_t  occupancy;
    data_t head_data;

    // --------------------------------------------------
    // write path, every accepted write is a push
    // --------------------------------------------------
    axil_write_slave u_write_slave (
        .clk_axi      (clk_axi),
        .axi_resetn_i (axi_resetn_i),
        .awvalid_i    (axi_awvalid_i),
        .awready_o    (axi_awready_o),
        .wdata_i      (axi_wdata_i),
        .wvalid_i     (axi_wvalid_i),
        .wready_o     (axi_wready_o),
        .bresp_o      (axi_bresp_o),
        .bvalid_o     (axi_bvalid_o),
        .bready_i     (axi_bready_i),
        .full_i       (full),
        .push_o       (push),
        .push_data_o  (push_data)
    );

    afifo_core u_core (
        .clk_axi        (clk_axi),
        .clk_periph     (clk_periph),
        .axi_resetn_i   (axi_resetn_i),
        .push_i         (push),
        .push_data_i    (push_data),
        .pop_i          (pop),
        .full_o         (full),
        .empty_axi_o    (empty_axi),
        .occupancy_o    (occupancy),
        .head_data_o    (head_data),
        .empty_periph_o (empty_periph)
    );

    periph_read_port u_periph_read (
        .clk_periph   (clk_periph),
        .axi_resetn_i (axi_resetn_i),
        .rd_en_i      (periph_rd_en_i),
        .empty_i      (empty_periph),
        .head_data_i  (head_data),
        .pop_o        (pop),
        .rdata_o      (periph_rdata_o),
        .rvalid_o     (periph_rvalid_o)
    );

    // status reads see the flags of the AXI domain
    axil_status_read u_status_read (
        .clk_axi      (clk_axi),
        .axi_resetn_i (axi_resetn_i),
        .araddr_i     (axi_araddr_i),
        .arvalid_i    (axi_arvalid_i),
        .arready_o    (axi_arready_o),
        .rdata_o      (axi_rdata_o),
        .rresp_o      (axi_rresp_o),
        .rvalid_o     (axi_rvalid_o),
        .rready_i     (axi_rready_i),
        .empty_i      (empty_axi),
        .full_i       (full),
        .occupancy_i  (occupancy)
    );

    assign periph_empty_o = empty_periph;
    // full flag lives in clk_axi
    assign periph_full_o  = full;

endmodule

`default_nettype wire

// File: rtl/axil_status_read.sv
`timescale 1ns/10ps
`default_nettype none

module axil_status_read (
    input  wire                       clk_axi,
    input  wire                       axi_resetn_i,
    input  wire afifo_pkg::axil_addr_t araddr_i,
    input  wire                       arvalid_i,
    output logic                      arready_o,
    output afifo_pkg::data_t          rdata_o,
    output afifo_pkg::resp_t          rresp_o,
    output logic                      rvalid_o,
    input  wire                       rready_i,
    input  wire                       empty_i,
    input  wire                       full_i,
    input  wire afifo_pkg::ptr_t      occupancy_i
);

    import afifo_pkg::*;

    data_t status_w;
    data_t rdata_q;
    resp_t rresp_q;
    logic  rvalid_q;

    // status word layout
    // bit 0 empty, bit 1 full, occupancy from bit 8 up
    always_comb begin
        status_w = '0;
        status_w[0] = empty_i;
        status_w[1] = full_i;
        status_w[8 +: $bits(ptr_t)] = occupancy_i;
    end

    // one read in flight at a time
    assign arready_o = !rvalid_q;

    always_ff @(posedge clk_axi or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            rvalid_q <= 1'b0;
        end else if (arvalid_i && arready_o) begin
            rvalid_q <= 1'b1;
        end else if (rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    // address decode, anything but status is an error
    always_ff @(posedge clk_axi) begin
        if (arvalid_i && arready_o) begin
            rdata_q <= (araddr_i == STATUS_ADDR) ? status_w : '0;
            rresp_q <= (araddr_i == STATUS_ADDR) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign rdata_o  = rdata_q;
    assign rresp_o  = rresp_q;
    assign rvalid_o = rvalid_q;

    a_rdata_stable: assert property (
        @(posedge clk_axi) disable iff (!axi_resetn_i)
        (rvalid_o && !rready_i) |=> (rvalid_o && $stable(rdata_o))
    );

endmodule

`default_nettype wire

// File: rtl/periph_read_port.sv
`timescale 1ns/10ps
`default_nettype none

module periph_read_port (
    input  wire                   clk_periph,
    input  wire                   axi_resetn_i,
    input  wire                   rd_en_i,
    input  wire                   empty_i,
    input  wire afifo_pkg::data_t head_data_i,
    output logic                  pop_o,
    output afifo_pkg::data_t      rdata_o,
    output logic                  rvalid_o
);

    import afifo_pkg::*;

    data_t rdata_q;
    logic  rvalid_q;

    // a request on an empty FIFO is simply dropped
    assign pop_o = rd_en_i && !empty_i;

    // valid pulses once per popped word
    always_ff @(posedge clk_periph or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= pop_o;
        end
    end

    // head word captured on the pop edge
    always_ff @(posedge clk_periph) begin
        if (pop_o) begin
            rdata_q <= head_data_i;
        end
    end

    assign rdata_o  = rdata_q;
    assign rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// File: rtl/afifo_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "afifo_params.svh"

module afifo_core (
    input  wire                   clk_axi,
    input  wire                   clk_periph,
    input  wire                   axi_resetn_i,
    input  wire                   push_i,
    input  wire afifo_pkg::data_t push_data_i,
    input  wire                   pop_i,
    output logic                  full_o,
    output logic                  empty_axi_o,
    output afifo_pkg::ptr_t       occupancy_o,
    output afifo_pkg::data_t      head_data_o,
    output logic                  empty_periph_o
);

    import afifo_pkg::*;

    localparam int MSB = `AFIFO_DEPTH_LOG2;
    localparam int unsigned DEPTH = 1 << `AFIFO_DEPTH_LOG2;
    localparam int STAGES = `AFIFO_SYNC_STAGES;

    // dual clock storage, written in clk_axi and read in clk_periph
    data_t mem [DEPTH];

    ptr_t wr_bin_q;
    ptr_t wr_gray_q;
    ptr_t wr_bin_nxt;
    ptr_t rd_bin_q;
    ptr_t rd_gray_q;
    ptr_t rd_bin_nxt;
    ptr_t rd_bin_axi;
    ptr_t wr_bin_periph;
    logic full_q;

    ptr_t [STAGES-1:0] rd_gray_sync_q;
    ptr_t [STAGES-1:0] wr_gray_sync_q;

    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[MSB] = gray[MSB];
        for (int i = MSB - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // --------------------------------------------------
    // write side, clk_axi
    // --------------------------------------------------
    assign wr_bin_nxt = wr_bin_q + ptr_t'(push_i);

    always_ff @(posedge clk_axi or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
            full_q    <= 1'b0;
        end else begin
            wr_bin_q  <= wr_bin_nxt;
            wr_gray_q <= bin2gray(wr_bin_nxt);
            // compare against the next pointer so a push shows up at once
            full_q    <= (ptr_t'(wr_bin_nxt - rd_bin_axi) == ptr_t'(DEPTH));
        end
    end

    always_ff @(posedge clk_axi) begin
        if (push_i) begin
            mem[wr_bin_q[MSB-1:0]] <= push_data_i;
        end
    end

    // read pointer into clk_axi
    always_ff @(posedge clk_axi or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            rd_gray_sync_q <= '0;
        end else begin
            rd_gray_sync_q <= {rd_gray_sync_q[STAGES-2:0], rd_gray_q};
        end
    end

    assign rd_bin_axi  = gray2bin(rd_gray_sync_q[STAGES-1]);
    assign full_o      = full_q;
    assign empty_axi_o = (wr_bin_q == rd_bin_axi);
    // pointers wrap together, so the difference is the fill level
    assign occupancy_o = wr_bin_q - rd_bin_axi;

    // --------------------------------------------------
    // read side, clk_periph
    // --------------------------------------------------
    assign rd_bin_nxt = rd_bin_q + ptr_t'(pop_i);

    always_ff @(posedge clk_periph or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            rd_bin_q  <= '0;
            rd_gray_q <= '0;
        end else begin
            rd_bin_q  <= rd_bin_nxt;
            rd_gray_q <= bin2gray(rd_bin_nxt);
        end
    end

    // write pointer into clk_periph
    always_ff @(posedge clk_periph or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            wr_gray_sync_q <= '0;
        end else begin
            wr_gray_sync_q <= {wr_gray_sync_q[STAGES-2:0], wr_gray_q};
        end
    end

    assign wr_bin_periph  = gray2bin(wr_gray_sync_q[STAGES-1]);
    assign empty_periph_o = (rd_bin_q == wr_bin_periph);
    assign head_data_o    = mem[rd_bin_q[MSB-1:0]];

    // the write slave must hold off when full
    a_no_push_full: assert property (
        @(posedge clk_axi) disable iff (!axi_resetn_i)
        push_i |-> !full_o
    );

    // the read port must hold off when empty
    a_no_pop_empty: assert property (
        @(posedge clk_periph) disable iff (!axi_resetn_i)
        pop_i |-> !empty_periph_o
    );

endmodule

`default_nettype wire

// File: rtl/axil_write_slave.sv
`timescale 1ns/10ps
`default_nettype none

module axil_write_slave (
    input  wire                clk_axi,
    input  wire                axi_resetn_i,
    input  wire                awvalid_i,
    output logic               awready_o,
    input  wire afifo_pkg::data_t wdata_i,
    input  wire                wvalid_i,
    output logic               wready_o,
    output afifo_pkg::resp_t   bresp_o,
    output logic               bvalid_o,
    input  wire                bready_i,
    input  wire                full_i,
    output logic               push_o,
    output afifo_pkg::data_t   push_data_o
);

    import afifo_pkg::*;

    wr_state_e state_q;
    wr_state_e state_d;
    data_t     wdata_q;
    resp_t     bresp_q;
    logic      aw_fire;
    logic      w_fire;
    logic      complete;

    // --------------------------------------------------
    // handshakes, ready follows the state directly
    // --------------------------------------------------
    assign awready_o = (state_q == WS_IDLE) || (state_q == WS_HAVE_W);
    assign wready_o  = (state_q == WS_IDLE) || (state_q == WS_HAVE_AW);
    assign bvalid_o  = (state_q == WS_RESP);
    assign bresp_o   = bresp_q;

    assign aw_fire = awvalid_i && awready_o;
    assign w_fire  = wvalid_i && wready_o;

    // second half of the pair arrives on this edge
    assign complete = ((state_q == WS_IDLE) && aw_fire && w_fire) ||
                      ((state_q == WS_HAVE_AW) && w_fire) ||
                      ((state_q == WS_HAVE_W) && aw_fire);

    // push only with room, a full FIFO turns into SLVERR
    assign push_o = complete && !full_i;

    // data comes from the held register once W went first
    assign push_data_o = (state_q == WS_HAVE_W) ? wdata_q : wdata_i;

    // --------------------------------------------------
    // state machine
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            WS_IDLE: begin
                if (complete) begin
                    state_d = WS_RESP;
                end else if (aw_fire) begin
                    state_d = WS_HAVE_AW;
                end else if (w_fire) begin
                    state_d = WS_HAVE_W;
                end
            end
            WS_HAVE_AW,
            WS_HAVE_W: begin
                if (complete) begin
                    state_d = WS_RESP;
                end
            end
            WS_RESP: begin
                // hold the response until the master takes it
                if (bready_i) begin
                    state_d = WS_IDLE;
                end
            end
            default: state_d = WS_IDLE;
        endcase
    end

    always_ff @(posedge clk_axi or negedge axi_resetn_i) begin
        if (!axi_resetn_i) begin
            state_q <= WS_IDLE;
            bresp_q <= RESP_OKAY;
        end else begin
            state_q <= state_d;
            if (complete) begin
                bresp_q <= full_i ? RESP_SLVERR : RESP_OKAY;
            end
        end
    end

    // W payload kept for the AW-late case
    always_ff @(posedge clk_axi) begin
        if (w_fire) begin
            wdata_q <= wdata_i;
        end
    end

    // a response once raised stays until accepted
    a_bvalid_hold: assert property (
        @(posedge clk_axi) disable iff (!axi_resetn_i)
        (bvalid_o && !bready_i) |=> (bvalid_o && $stable(bresp_o))
    );

endmodule

`default_nettype wire

// File: rtl/afifo_pkg.sv
`default_nettype none

`include "afifo_params.svh"

package afifo_pkg;

    // data word and AXI address
    typedef logic [`AFIFO_DATA_W-1:0] data_t;
    typedef logic [`AFIFO_ADDR_W-1:0] axil_addr_t;

    // pointer with one extra wrap bit, also wide enough for occupancy
    typedef logic [`AFIFO_DEPTH_LOG2:0] ptr_t;

    // AXI response codes
    typedef logic [1:0] resp_t;
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // only register in the read map
    localparam axil_addr_t STATUS_ADDR = '0;

    // write slave states
    typedef enum logic [1:0] {WS_IDLE, WS_HAVE_AW, WS_HAVE_W, WS_RESP} wr_state_e;

endpackage

`default_nettype wire

// File: rtl/afifo_params.svh
`ifndef AFIFO_PARAMS_SVH
`define AFIFO_PARAMS_SVH

// --------------------------------------------------
// widths and sizes shared by the whole FIFO design
// --------------------------------------------------

// one FIFO word, also the AXI data width
`define AFIFO_DATA_W 32

// AXI address width
`define AFIFO_ADDR_W 4

// log2 of the FIFO depth, 3 gives 8 words
`define AFIFO_DEPTH_LOG2 3

// flops in each pointer synchronizer
`define AFIFO_SYNC_STAGES 2

`endif
